/* all.f */
+incdir+source
+incdir+tb
source/cavlcPkg.sv
source/coeffAnalyzer.sv
source/levelCodeEncoder.sv
source/levelResultCollector.sv
source/cavlcLevelTop.sv
tb/tbCavlcLevel.sv

/* runSim.sh */
#!/bin/sh
# build and run the CAVLC level testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbCavlcLevel \
    --Mdir obj_dir -o simCavlcLevel -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simCavlcLevel)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

/* source/cavlcLevelTop.sv */
`timescale 1ns/1ps
`include "cavlcLevel_params.svh"

module cavlcLevelTop (
    input  logic                        clk,
    input  logic                        enc_rst,
    input  logic                        blockValid,
    input  cavlcPkg::coeffBlock_t       blockIn,
    output logic                        busy,
    output logic                        resultValid,
    output cavlcPkg::levelResult_t      resultOut
);

    logic [`NUM_LANES-1:0]      encLoad;
    logic [`NUM_LANES-1:0]      laneIdle;
    logic [`NUM_LANES-1:0]      laneDone;
    logic [`NUM_LANES-1:0]      taken;
    cavlcPkg::levelJob_t        job;            // shared by every lane
    cavlcPkg::levelResult_t     laneResult [`NUM_LANES];

    coeffAnalyzer uAnalyzer (
        .clk        (clk),
        .enc_rst    (enc_rst),
        .blockValid (blockValid),
        .blockIn    (blockIn),
        .laneIdle   (laneIdle),
        .busy       (busy),
        .encLoad    (encLoad),
        .job        (job)
    );

    for (genvar k = 0; k < `NUM_LANES; k++) begin : gLane
        levelCodeEncoder uLane (
            .clk      (clk),
            .enc_rst  (enc_rst),
            .encLoad  (encLoad[k]),
            .job      (job),
            .taken    (taken[k]),
            .laneIdle (laneIdle[k]),
            .laneDone (laneDone[k]),
            .result   (laneResult[k])
        );
    end

    levelResultCollector uCollector (
        .clk         (clk),
        .enc_rst     (enc_rst),
        .laneDone    (laneDone),
        .result      (laneResult),
        .taken       (taken),
        .resultValid (resultValid),
        .resultOut   (resultOut)
    );

endmodule : cavlcLevelTop

/* source/cavlcLevel_params.svh */
`ifndef CAVLC_LEVEL_PARAMS_SVH
`define CAVLC_LEVEL_PARAMS_SVH

// encoder lanes, 2 4 or 8
`define NUM_LANES 4

`define COEFF_W 8
`define CODE_W 50
`define BITS_W 6
`define TAG_W 8

// lane pointer width
`define LANE_W ($clog2(`NUM_LANES))

`endif

/* source/cavlcPkg.sv */
`include "cavlcLevel_params.svh"

package cavlcPkg;

    // one 4x4 residual block, coeff[0] is the first zigzag position
    typedef struct packed {
        logic [`TAG_W-1:0]              tag;
        logic [15:0][`COEFF_W-1:0]      coeff;
    } coeffBlock_t;

    // work order for one encoder lane
    typedef struct packed {
        logic [`TAG_W-1:0]              tag;
        logic [4:0]                     totalCoeff;
        logic [1:0]                     trailingOnes;
        logic [4:0]                     levelCnt;    // valid entries in levels
        logic [15:0][`COEFF_W-1:0]      levels;      // reverse scan order
    } levelJob_t;

    typedef struct packed {
        logic [`TAG_W-1:0]              tag;
        logic [`CODE_W-1:0]             code;        // right aligned bitstring
        logic [`BITS_W-1:0]             bits;
    } levelResult_t;

    typedef enum logic [1:0] {
        laneIdle,
        laneEncoding,
        laneHolding
    } laneState_t;

endpackage : cavlcPkg

/* source/coeffAnalyzer.sv */
`timescale 1ns/1ps
`include "cavlcLevel_params.svh"

module coeffAnalyzer (
    input  logic                        clk,
    input  logic                        enc_rst,
    input  logic                        blockValid,
    input  cavlcPkg::coeffBlock_t       blockIn,
    input  logic [`NUM_LANES-1:0]       laneIdle,
    output logic                        busy,
    output logic [`NUM_LANES-1:0]       encLoad,
    output cavlcPkg::levelJob_t         job
);

    cavlcPkg::coeffBlock_t          blockReg;
    logic                           pendValid;   // blockReg waits for its lane
    logic [`LANE_W-1:0]             rrPtr;
    logic                           accept;
    logic                           dispatch;

    logic signed [`COEFF_W-1:0]     scanCoeff;
    logic [4:0]                     nzCnt;
    logic [4:0]                     lvlCnt;
    logic [1:0]                     onesCnt;
    logic                           onesOpen;
    logic [15:0][`COEFF_W-1:0]      levelList;

    assign dispatch = pendValid && laneIdle[rrPtr];
    assign busy     = pendValid && !laneIdle[rrPtr];
    assign accept   = blockValid && !busy;

    always_comb begin
        encLoad         = '0;
        encLoad[rrPtr]  = dispatch;
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            pendValid <= 1'b0;
            rrPtr     <= '0;
        end else begin
            if (accept)
                pendValid <= 1'b1;
            else if (dispatch)
                pendValid <= 1'b0;

            if (dispatch) begin
                if (int'(rrPtr) == `NUM_LANES - 1)
                    rrPtr <= '0;
                else
                    rrPtr <= rrPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            blockReg <= blockIn;
    end

    // walk from the highest frequency position down to DC
    always_comb begin
        nzCnt     = 5'd0;
        lvlCnt    = 5'd0;
        onesCnt   = 2'd0;
        onesOpen  = 1'b1;
        levelList = '0;
        scanCoeff = '0;
        for (int i = 15; i >= 0; i--) begin
            scanCoeff = $signed(blockReg.coeff[i]);
            if (scanCoeff != 0) begin
                nzCnt = nzCnt + 5'd1;
                if (onesOpen && onesCnt < 2'd3 && (scanCoeff == 1 || scanCoeff == -1)) begin
                    onesCnt = onesCnt + 2'd1;
                end else begin
                    onesOpen                = 1'b0;  // trailing ones end at first other value
                    levelList[lvlCnt[3:0]]  = scanCoeff;
                    lvlCnt                  = lvlCnt + 5'd1;
                end
            end
        end
    end

    assign job.tag          = blockReg.tag;
    assign job.totalCoeff   = nzCnt;
    assign job.trailingOnes = onesCnt;
    assign job.levelCnt     = lvlCnt;
    assign job.levels       = levelList;

    // the loaded lane has left idle by the next edge
    loadAccepted: assert property (@(posedge clk) disable iff (enc_rst)
        |encLoad |=> (laneIdle & $past(encLoad)) == '0)
        else $error("coeffAnalyzer: loaded lane still idle");

endmodule : coeffAnalyzer

/* source/levelCodeEncoder.sv */
`timescale 1ns/1ps
`include "cavlcLevel_params.svh"

module levelCodeEncoder (
    input  logic                        clk,
    input  logic                        enc_rst,
    input  logic                        encLoad,
    input  cavlcPkg::levelJob_t         job,
    input  logic                        taken,
    output logic                        laneIdle,
    output logic                        laneDone,
    output cavlcPkg::levelResult_t      result
);

    localparam int LC_W = `COEFF_W + 2;

    cavlcPkg::laneState_t           state;
    logic [4:0]                     idx;
    logic [2:0]                     suffixLen;

    logic [`TAG_W-1:0]              tagReg;
    logic [1:0]                     t1Reg;
    logic [4:0]                     levelCntReg;
    logic [15:0][`COEFF_W-1:0]      levelsReg;
    logic [`CODE_W-1:0]             codeReg;
    logic [`BITS_W-1:0]             bitsReg;

    logic [`COEFF_W-1:0]            curLevel;
    logic [`COEFF_W-1:0]            levelAbs;
    logic [LC_W-1:0]                levelCode;
    logic [LC_W-1:0]                shifted;
    logic [LC_W-1:0]                lvlMask;
    logic [LC_W-1:0]                escCode;
    logic [3:0]                     prefix;
    logic [11:0]                    suffix;
    logic [3:0]                     sufLen;
    logic [2:0]                     nextSuffixLen;
    logic [`CODE_W-1:0]             nextCode;
    logic [`BITS_W-1:0]             nextBits;
    logic                           loadNow;
    logic                           lastLevel;

    assign loadNow   = (state == cavlcPkg::laneIdle) && encLoad;
    assign lastLevel = (idx + 5'd1 == levelCntReg);

    assign curLevel = levelsReg[idx[3:0]];
    assign levelAbs = curLevel[`COEFF_W-1] ? (~curLevel + 1'b1) : curLevel;

    always_comb begin
        // 2L-2 for positive, -2L-1 for negative
        if (curLevel[`COEFF_W-1])
            levelCode = (LC_W'(levelAbs) << 1) - LC_W'(1);
        else
            levelCode = (LC_W'(levelAbs) << 1) - LC_W'(2);
        if (idx == 5'd0 && t1Reg < 2'd3)
            levelCode = levelCode - LC_W'(2);

        shifted = levelCode >> suffixLen;
        lvlMask = (LC_W'(1) << suffixLen) - LC_W'(1);
        escCode = '0;

        if (shifted < LC_W'(14)) begin
            prefix = shifted[3:0];
            suffix = 12'(levelCode & lvlMask);
            sufLen = {1'b0, suffixLen};
        end else if (suffixLen == 3'd0 && levelCode < LC_W'(30)) begin
            prefix = 4'd14;
            suffix = 12'(levelCode - LC_W'(14));  // 4-bit suffix
            sufLen = 4'd4;
        end else if (suffixLen != 3'd0 && shifted == LC_W'(14)) begin
            prefix = 4'd14;
            suffix = 12'(levelCode & lvlMask);
            sufLen = {1'b0, suffixLen};
        end else begin
            prefix  = 4'd15;  // escape
            escCode = levelCode - (LC_W'(15) << suffixLen);
            if (suffixLen == 3'd0)
                escCode = escCode - LC_W'(15);
            suffix  = 12'(escCode);
            sufLen  = 4'd12;
        end

        nextSuffixLen = suffixLen;
        if (suffixLen == 3'd0)
            nextSuffixLen = 3'd1;
        if (levelAbs > (`COEFF_W'(3) << (nextSuffixLen - 3'd1)) && nextSuffixLen < 3'd6)
            nextSuffixLen = nextSuffixLen + 3'd1;

        // prefix zeros, a one, then the suffix
        nextCode = (((codeReg << (prefix + 5'd1)) | `CODE_W'(1)) << sufLen) | `CODE_W'(suffix);
        nextBits = bitsReg + `BITS_W'(prefix) + `BITS_W'(1) + `BITS_W'(sufLen);
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            state     <= cavlcPkg::laneIdle;
            idx       <= 5'd0;
            suffixLen <= 3'd0;
        end else begin
            case (state)
                cavlcPkg::laneIdle: begin
                    if (encLoad) begin
                        state     <= (job.levelCnt == 5'd0) ? cavlcPkg::laneHolding
                                                            : cavlcPkg::laneEncoding;
                        idx       <= 5'd0;
                        suffixLen <= (job.totalCoeff > 5'd10 && job.trailingOnes < 2'd3)
                                     ? 3'd1 : 3'd0;
                    end
                end
                cavlcPkg::laneEncoding: begin
                    idx       <= idx + 5'd1;
                    suffixLen <= nextSuffixLen;
                    if (lastLevel)
                        state <= cavlcPkg::laneHolding;
                end
                cavlcPkg::laneHolding: begin
                    if (taken)
                        state <= cavlcPkg::laneIdle;
                end
                default: state <= cavlcPkg::laneIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (loadNow) begin
            tagReg      <= job.tag;
            t1Reg       <= job.trailingOnes;
            levelCntReg <= job.levelCnt;
            levelsReg   <= job.levels;
            codeReg     <= '0;
            bitsReg     <= '0;
        end else if (state == cavlcPkg::laneEncoding) begin
            codeReg <= nextCode;
            bitsReg <= nextBits;
        end
    end

    assign laneIdle    = (state == cavlcPkg::laneIdle);
    assign laneDone    = (state == cavlcPkg::laneHolding);
    assign result.tag  = tagReg;
    assign result.code = codeReg;
    assign result.bits = bitsReg;

    // the analyzer only loads a lane that reported idle
    loadWhenIdle: assert property (@(posedge clk) disable iff (enc_rst)
        encLoad |-> state == cavlcPkg::laneIdle)
        else $error("levelCodeEncoder: encLoad while lane busy");

endmodule : levelCodeEncoder

/* source/levelResultCollector.sv */
`timescale 1ns/1ps
`include "cavlcLevel_params.svh"

module levelResultCollector (
    input  logic                        clk,
    input  logic                        enc_rst,
    input  logic [`NUM_LANES-1:0]       laneDone,
    input  cavlcPkg::levelResult_t      result [`NUM_LANES],
    output logic [`NUM_LANES-1:0]       taken,
    output logic                        resultValid,
    output cavlcPkg::levelResult_t      resultOut
);

    logic [`LANE_W-1:0]     rdPtr;   // follows the analyzer dispatch order
    logic                   grab;

    assign grab = laneDone[rdPtr];

    always_comb begin
        taken        = '0;
        taken[rdPtr] = grab;
    end

    always_ff @(posedge clk) begin
        if (enc_rst) begin
            rdPtr       <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= grab;
            if (grab) begin
                if (int'(rdPtr) == `NUM_LANES - 1)
                    rdPtr <= '0;
                else
                    rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grab)
            resultOut <= result[rdPtr];
    end

    // a released lane stops offering its result
    takenReleases: assert property (@(posedge clk) disable iff (enc_rst)
        |taken |=> (laneDone & $past(taken)) == '0)
        else $error("levelResultCollector: lane still done after taken");

endmodule : levelResultCollector

/* tb/cavlcLevelModel.svh */
`ifndef CAVLC_LEVEL_MODEL_SVH
`define CAVLC_LEVEL_MODEL_SVH

`include "cavlcLevel_params.svh"

// level string of one block; bits is the full length, even past the code width
function automatic void modelLevels(
    input  cavlcPkg::coeffBlock_t   blk,
    output logic [63:0]             code,
    output int                      bits
);
    int lv [16];
    int nLv;
    int total;
    int ones;
    bit onesDone;
    int c;
    int sufLen;
    int lvCode;
    int prefix;
    int sufBits;
    int sufVal;

    nLv      = 0;
    total    = 0;
    ones     = 0;
    onesDone = 1'b0;
    code     = '0;
    bits     = 0;
    for (int pos = 15; pos >= 0; pos--) begin
        c = int'($signed(blk.coeff[pos]));
        if (c != 0) begin
            total++;
            if (!onesDone && ones < 3 && (c == 1 || c == -1)) begin
                ones++;
            end else begin
                onesDone = 1'b1;
                lv[nLv]  = c;
                nLv++;
            end
        end
    end

    sufLen = (total > 10 && ones < 3) ? 1 : 0;
    for (int i = 0; i < nLv; i++) begin
        lvCode = (lv[i] > 0) ? 2 * lv[i] - 2 : -2 * lv[i] - 1;
        if (i == 0 && ones < 3)
            lvCode = lvCode - 2;
        prefix  = 15;   // escape unless a shorter form fits
        sufBits = 12;
        sufVal  = (sufLen == 0) ? lvCode - 30 : lvCode - (15 << sufLen);
        if (sufLen == 0 && lvCode < 14) begin
            prefix  = lvCode;
            sufBits = 0;
            sufVal  = 0;
        end else if (sufLen == 0 && lvCode < 30) begin
            prefix  = 14;
            sufBits = 4;
            sufVal  = lvCode - 14;
        end else if (sufLen != 0 && lvCode < (15 << sufLen)) begin
            prefix  = lvCode >> sufLen;
            sufBits = sufLen;
            sufVal  = lvCode % (1 << sufLen);
        end
        code = (code << (prefix + 1 + sufBits)) | (64'd1 << sufBits) | 64'(sufVal);
        bits = bits + prefix + 1 + sufBits;
        if (sufLen == 0)
            sufLen = 1;
        if ((lv[i] > 0 ? lv[i] : -lv[i]) > (3 << (sufLen - 1)) && sufLen < 6)
            sufLen++;
    end
endfunction

function automatic cavlcPkg::levelResult_t expectedResult(input cavlcPkg::coeffBlock_t blk);
    cavlcPkg::levelResult_t r;
    logic [63:0]            code;
    int                     bits;

    modelLevels(blk, code, bits);
    r.tag  = blk.tag;
    r.code = code[`CODE_W-1:0];
    r.bits = `BITS_W'(bits);
    return r;
endfunction

`endif

/* tb/tbCavlcLevel.sv */
`timescale 1ns/1ps
`include "cavlcLevel_params.svh"

module tbCavlcLevel;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_RANDOM  = 80;
    localparam int NUM_BLOCKS  = NUM_RANDOM + 9;
    localparam int WATCHDOG_NS = (NUM_BLOCKS * 30 + 100) * CLK_PERIOD;

    logic                       clk;
    logic                       enc_rst;
    logic                       blockValid;
    cavlcPkg::coeffBlock_t      blockIn;
    logic                       busy;
    logic                       resultValid;
    cavlcPkg::levelResult_t     resultOut;

    cavlcPkg::levelResult_t     expQ [$];
    cavlcPkg::levelResult_t     headExp;     // oldest outstanding result
    logic                       headValid;
    logic                       sentAny;
    logic [31:0]                lcgState;
    int                         mismatchCnt;
    int                         otherCnt;
    int                         checkedCnt;

    `include "cavlcLevelModel.svh"

    cavlcLevelTop UUT (
        .clk         (clk),
        .enc_rst     (enc_rst),
        .blockValid  (blockValid),
        .blockIn     (blockIn),
        .busy        (busy),
        .resultValid (resultValid),
        .resultOut   (resultOut)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int magOf(input logic [7:0] c);
        return c[7] ? -int'($signed(c)) : int'(c);
    endfunction

    // halve the largest coefficient until the level string fits the code width
    function automatic cavlcPkg::coeffBlock_t capLength(input cavlcPkg::coeffBlock_t blk);
        cavlcPkg::coeffBlock_t  b;
        logic [63:0]            code;
        int                     bits;
        int                     big;

        b = blk;
        modelLevels(b, code, bits);
        while (bits > `CODE_W) begin
            big = 0;
            for (int p = 1; p < 16; p++)
                if (magOf(b.coeff[p]) > magOf(b.coeff[big]))
                    big = p;
            b.coeff[big] = 8'(int'($signed(b.coeff[big])) / 2);
            modelLevels(b, code, bits);
        end
        return b;
    endfunction

    function automatic cavlcPkg::coeffBlock_t randomBlock(input logic [7:0] tag);
        cavlcPkg::coeffBlock_t  b;
        logic [31:0]            r;
        int                     density;
        int                     mag;

        b       = '0;
        b.tag   = tag;
        density = int'(nextRand() % 32'd17);   // nonzero positions per 16
        for (int p = 0; p < 16; p++) begin
            r = nextRand();
            if (int'(r[7:4]) < density) begin
                case (r[10:8])
                    3'd0, 3'd1, 3'd2: mag = 1;
                    3'd3, 3'd4:       mag = 2 + int'(r[12:11]);
                    3'd5:             mag = 6 + int'(r[15:13]);
                    default:          mag = 1 + int'(r[20:16]);  // up to 32
                endcase
                b.coeff[p] = r[21] ? 8'(-mag) : 8'(mag);
            end
        end
        return capLength(b);
    endfunction

    // waits out busy, then holds the strobe for one cycle
    task automatic sendBlock(input cavlcPkg::coeffBlock_t b);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        blockValid = 1'b1;
        blockIn    = b;
        sentAny    = 1'b1;
        @(posedge clk);
        #1;
        blockValid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (enc_rst) begin
            expQ.delete();
        end else begin
            if (resultValid && expQ.size() != 0) begin
                void'(expQ.pop_front());
                checkedCnt++;
            end
            if (blockValid && !busy)
                expQ.push_back(expectedResult(blockIn));
        end
        headValid <= (expQ.size() != 0);
        if (expQ.size() != 0)
            headExp <= expQ[0];
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (enc_rst)
        !sentAny |-> !busy && !resultValid)
        else begin
            otherCnt++;
            $display("busy or resultValid went high before any block was sent");
        end

    resultExpected: assert property (@(posedge clk) disable iff (enc_rst)
        resultValid |-> headValid)
        else begin
            otherCnt++;
            $display("a result arrived while no block was outstanding");
        end

    tagMatch: assert property (@(posedge clk) disable iff (enc_rst)
        resultValid && headValid |-> resultOut.tag == headExp.tag)
        else begin
            mismatchCnt++;
            $display("mismatch resultOut.tag: got %h, expected %h",
                     $sampled(resultOut.tag), $sampled(headExp.tag));
        end

    codeMatch: assert property (@(posedge clk) disable iff (enc_rst)
        resultValid && headValid |-> resultOut.code == headExp.code)
        else begin
            mismatchCnt++;
            $display("mismatch resultOut.code: got %h, expected %h",
                     $sampled(resultOut.code), $sampled(headExp.code));
        end

    bitsMatch: assert property (@(posedge clk) disable iff (enc_rst)
        resultValid && headValid |-> resultOut.bits == headExp.bits)
        else begin
            mismatchCnt++;
            $display("mismatch resultOut.bits: got %h, expected %h",
                     $sampled(resultOut.bits), $sampled(headExp.bits));
        end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: %0d results still outstanding after %0d ns", expQ.size(), WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        enc_rst     = 1'b1;
        blockValid  = 1'b0;
        blockIn     = '0;
        sentAny     = 1'b0;
        lcgState    = 32'h8265_3964;
        mismatchCnt = 0;
        otherCnt    = 0;
        checkedCnt  = 0;
        repeat (2) @(posedge clk);
        #1;
        enc_rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        // coefficient bytes run from position 15 down to DC
        sendBlock({8'd1, 128'h0});
        sendBlock({8'd2, 128'h0000_0000_0000_0000_0000_0100_ff00_0001}); // only trailing ones
        sendBlock({8'd3, 128'h0000_0000_0000_0000_0000_01fe_0103_fb0c}); // suffix growth
        sendBlock({8'd4, 128'h0000_0000_0002_01ff_01fe_01ff_0201_ff02}); // 11 nonzeros
        sendBlock({8'd5, 128'h0000_0000_ff01_04fe_02ff_0105_fd03_06fa}); // 12 nonzeros
        sendBlock({8'd6, 128'h09});      // prefix 14 at suffixLength 0
        sendBlock({8'd7, 128'h020f});    // prefix 14 at suffixLength 1
        sendBlock({8'd8, 128'he014});    // escape at suffixLength 0
        sendBlock({8'd9, 128'h0214});    // escape at suffixLength 1
        for (int n = 0; n < NUM_RANDOM; n++)
            sendBlock(randomBlock(8'(10 + n)));

        while (expQ.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);

        $display("checked %0d of %0d results, %0d mismatches, %0d other errors",
                 checkedCnt, NUM_BLOCKS, mismatchCnt, otherCnt);
        if (mismatchCnt == 0 && otherCnt == 0 && checkedCnt == NUM_BLOCKS) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tbCavlcLevel
